// File: rtl/rec_pkg.sv
package rec_pkg;

    // sample and memory word share one width
    localparam int SAMPLE_W  = 16;
    localparam int ADDR_W    = 20;
    localparam int LEN_W     = 32;  // stored high half first
    localparam int HDR_WORDS = 2;   // recording starts right after the header

    typedef enum logic [3:0] {
        REC_NONE   = 4'd0,
        REC_PLAY   = 4'd1,
        REC_PAUSE  = 4'd2,
        REC_STOP   = 4'd3,
        REC_RECORD = 4'd4
    } rec_code_e;

    // 3 falls back to normal
    typedef enum logic [1:0] {
        MODE_NORMAL = 2'd0,
        MODE_SLOW   = 2'd1,
        MODE_FAST   = 2'd2
    } play_mode_e;

    // command word with code in the msb
    typedef struct packed {
        rec_code_e  code;
        play_mode_e mode;
        logic [3:0] speed;     // 1..8 where 0 acts as 1
        logic       interp;
        logic [4:0] reserved;
    } rec_event_t;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [SAMPLE_W-1:0] wdata;
        logic                we;
        logic                re;
    } mem_req_t;

endpackage

// File: rtl/interp_slope.sv
`timescale 1ns/1ps

module interp_slope (
    input  logic [rec_pkg::SAMPLE_W-1:0] i_diff,
    input  logic [3:0]                   i_speed,
    output logic [rec_pkg::SAMPLE_W-1:0] o_slope
);
    import rec_pkg::*;

    logic signed [SAMPLE_W-1:0] d;

    assign d = $signed(i_diff);  // two's complement difference

    // approximates d/speed with shifts only
    always_comb begin
        case (i_speed)
            4'd2:    o_slope = d >>> 1;
            4'd3:    o_slope = (d >>> 2) + (d >>> 4) + (d >>> 6);  // ~0.328
            4'd4:    o_slope = d >>> 2;
            4'd5:    o_slope = (d >>> 3) + (d >>> 4) + (d >>> 6);  // ~0.203
            4'd6:    o_slope = (d >>> 3) + (d >>> 5) + (d >>> 7);  // ~0.164
            4'd7:    o_slope = (d >>> 3) + (d >>> 6) + (d >>> 9);  // ~0.143
            4'd8:    o_slope = d >>> 3;
            default: o_slope = '0;  // no ramp for speed 1 or out of range
        endcase
    end

endmodule

// File: rtl/play_stepper.sv
`timescale 1ns/1ps

module play_stepper (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_start,
    input  logic                         i_accept,
    input  rec_pkg::play_mode_e          i_mode,
    input  logic [3:0]                   i_speed,
    input  logic                         i_interp,
    input  logic [rec_pkg::ADDR_W-1:0]   i_addr,
    input  logic [rec_pkg::SAMPLE_W-1:0] i_word,
    output logic [rec_pkg::ADDR_W-1:0]   o_next_addr,
    output logic                         o_at_boundary,
    output logic [rec_pkg::SAMPLE_W-1:0] o_sample
);
    import rec_pkg::*;

    logic [3:0]          eff_speed;
    logic [3:0]          rep_cnt_r;  // output index k within the current word
    logic [SAMPLE_W-1:0] prev_r;     // p, last word passed
    logic [SAMPLE_W-1:0] acc_r;      // k * slope
    logic [SAMPLE_W-1:0] diff;
    logic [SAMPLE_W-1:0] slope;
    logic                slow;
    logic                last_rep;

    assign eff_speed = (i_speed == 4'd0) ? 4'd1 : i_speed;
    assign slow      = (i_mode == MODE_SLOW);
    assign last_rep  = (rep_cnt_r == eff_speed - 4'd1);
    assign diff      = i_word - prev_r;

    interp_slope u_slope (
        .i_diff  (diff),
        .i_speed (eff_speed),
        .o_slope (slope)
    );

    // step taken on the next accept
    always_comb begin
        o_next_addr   = i_addr + 1'b1;
        o_at_boundary = 1'b1;
        o_sample      = i_word;
        case (i_mode)
            MODE_FAST: begin
                o_next_addr = i_addr + {{(ADDR_W-4){1'b0}}, eff_speed};
            end
            MODE_SLOW: begin
                o_at_boundary = last_rep;  // word ends only after its last repeat
                o_next_addr   = last_rep ? i_addr + 1'b1 : i_addr;
                o_sample      = i_interp ? prev_r + acc_r : prev_r;
            end
            default: ;  // normal and code 3
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            rep_cnt_r <= '0;
        end else if (i_start) begin
            rep_cnt_r <= '0;
        end else if (i_accept && slow) begin
            rep_cnt_r <= last_rep ? 4'd0 : rep_cnt_r + 4'd1;
        end
    end

    // held word and ramp restart from zero at each playback start
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            prev_r <= '0;
            acc_r  <= '0;
        end else if (i_accept && slow) begin
            if (last_rep) begin
                prev_r <= i_word;
                acc_r  <= '0;
            end else begin
                acc_r <= acc_r + slope;
            end
        end
    end

    // repeat index never reaches the effective speed
    a_rep_range: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_accept && slow) |-> (rep_cnt_r < eff_speed));

endmodule

// File: rtl/rec_ctrl.sv
`timescale 1ns/1ps

module rec_ctrl (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  rec_pkg::rec_event_t          i_event,
    input  logic [rec_pkg::SAMPLE_W-1:0] i_adc_data,
    input  logic                         i_adc_valid,
    output logic                         o_adc_ready,
    output rec_pkg::mem_req_t            o_mem,
    input  logic [rec_pkg::SAMPLE_W-1:0] i_mem_rdata,
    input  logic                         i_dac_ready,
    output logic                         o_dac_valid,
    output logic                         o_stop_signal,
    output logic                         o_play_start,
    output logic                         o_play_accept,
    output logic [rec_pkg::ADDR_W-1:0]   o_play_addr,
    input  logic [rec_pkg::ADDR_W-1:0]   i_next_addr,
    input  logic                         i_at_boundary
);
    import rec_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_REC,
        S_REC_PAUSE,
        S_HDR_WR,
        S_HDR_RD,
        S_PLAY,
        S_PLAY_PAUSE
    } state_e;

    state_e            state_r, state_nx;
    logic [ADDR_W-1:0] addr_r, addr_nx;          // record or play address
    logic [LEN_W-1:0]  len_r, len_nx;
    logic              hdr_cnt_r, hdr_cnt_nx;    // header word 0 or 1
    logic              to_pause_r, to_pause_nx;  // header write target
    logic              dac_valid_nx;
    logic              stop_nx;
    logic              play_end;

    assign o_adc_ready   = (state_r == S_REC);
    assign o_play_accept = o_dac_valid && i_dac_ready;
    assign o_play_addr   = addr_r;

    // the step being consumed lands on or past the length
    assign play_end = o_play_accept && i_at_boundary &&
                      ({{(LEN_W-ADDR_W){1'b0}}, i_next_addr} >= len_r);

    always_comb begin
        o_mem = '0;
        case (state_r)
            S_REC: begin
                o_mem.addr  = addr_r;
                o_mem.wdata = i_adc_data;
                o_mem.we    = i_adc_valid;
            end
            S_HDR_WR: begin
                o_mem.addr  = {{(ADDR_W-1){1'b0}}, hdr_cnt_r};
                o_mem.wdata = hdr_cnt_r ? len_r[SAMPLE_W-1:0] : len_r[LEN_W-1:SAMPLE_W];
                o_mem.we    = 1'b1;
            end
            S_HDR_RD: begin
                o_mem.addr = {{(ADDR_W-1){1'b0}}, hdr_cnt_r};
                o_mem.re   = 1'b1;
            end
            S_PLAY: begin
                o_mem.addr = addr_r;
                o_mem.re   = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_nx     = state_r;
        addr_nx      = addr_r;
        len_nx       = len_r;
        hdr_cnt_nx   = hdr_cnt_r;
        to_pause_nx  = to_pause_r;
        dac_valid_nx = o_dac_valid;
        stop_nx      = 1'b0;
        o_play_start = 1'b0;
        case (state_r)
            S_IDLE: begin
                if (i_event.code == REC_PLAY) begin
                    state_nx   = S_HDR_RD;
                    hdr_cnt_nx = 1'b0;
                end else if (i_event.code == REC_RECORD) begin
                    state_nx = S_REC;
                    addr_nx  = ADDR_W'(HDR_WORDS);
                end
            end
            S_REC: begin
                if (i_adc_valid) addr_nx = addr_r + 1'b1;  // sample taken
                if (i_event.code == REC_PAUSE || i_event.code == REC_STOP) begin
                    state_nx    = S_HDR_WR;
                    hdr_cnt_nx  = 1'b0;
                    to_pause_nx = (i_event.code == REC_PAUSE);
                    len_nx      = {{(LEN_W-ADDR_W){1'b0}}, addr_nx};
                end
            end
            S_HDR_WR: begin
                hdr_cnt_nx = ~hdr_cnt_r;
                if (hdr_cnt_r) state_nx = to_pause_r ? S_REC_PAUSE : S_IDLE;
            end
            S_REC_PAUSE: begin
                case (i_event.code)
                    REC_PLAY: begin
                        state_nx   = S_HDR_RD;
                        hdr_cnt_nx = 1'b0;
                    end
                    REC_RECORD: begin
                        state_nx = S_REC;
                        addr_nx  = len_r[ADDR_W-1:0];  // resume after last word
                    end
                    REC_STOP: state_nx = S_IDLE;
                    default: ;
                endcase
            end
            S_HDR_RD: begin
                hdr_cnt_nx = ~hdr_cnt_r;
                if (!hdr_cnt_r) begin
                    len_nx[LEN_W-1:SAMPLE_W] = i_mem_rdata;
                end else begin
                    len_nx[SAMPLE_W-1:0] = i_mem_rdata;
                    addr_nx              = ADDR_W'(HDR_WORDS);
                    if ({len_r[LEN_W-1:SAMPLE_W], i_mem_rdata} <= LEN_W'(HDR_WORDS)) begin
                        state_nx = S_IDLE;  // empty recording ends at once
                        stop_nx  = 1'b1;
                    end else begin
                        state_nx     = S_PLAY;
                        dac_valid_nx = 1'b1;
                        o_play_start = 1'b1;
                    end
                end
            end
            S_PLAY: begin
                if (o_play_accept) addr_nx = i_next_addr;
                if (play_end) begin
                    state_nx     = S_IDLE;
                    dac_valid_nx = 1'b0;
                    stop_nx      = 1'b1;
                end else if (i_event.code == REC_PAUSE) begin
                    state_nx     = S_PLAY_PAUSE;
                    dac_valid_nx = 1'b0;
                end else if (i_event.code == REC_STOP) begin
                    state_nx     = S_IDLE;
                    dac_valid_nx = 1'b0;
                end
            end
            S_PLAY_PAUSE: begin
                case (i_event.code)
                    REC_PLAY: begin
                        state_nx     = S_PLAY;  // header already loaded
                        dac_valid_nx = 1'b1;
                    end
                    REC_RECORD: begin
                        state_nx = S_REC;
                        addr_nx  = ADDR_W'(HDR_WORDS);
                    end
                    REC_STOP: state_nx = S_IDLE;
                    default: ;
                endcase
            end
            default: state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r       <= S_IDLE;
            addr_r        <= '0;
            len_r         <= LEN_W'(HDR_WORDS);
            hdr_cnt_r     <= 1'b0;
            to_pause_r    <= 1'b0;
            o_dac_valid   <= 1'b0;
            o_stop_signal <= 1'b0;
        end else begin
            state_r       <= state_nx;
            addr_r        <= addr_nx;
            len_r         <= len_nx;
            hdr_cnt_r     <= hdr_cnt_nx;
            to_pause_r    <= to_pause_nx;
            o_dac_valid   <= dac_valid_nx;
            o_stop_signal <= stop_nx;
        end
    end

    a_mem_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_mem.we && o_mem.re));

    // ADC and DAC sides never active together
    a_adc_rec: assert property (@(posedge i_clk) disable iff (i_rst)
        o_adc_ready |-> (state_r == S_REC) && !o_dac_valid);

    // end pulse always comes with the DAC stream closed
    a_stop_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stop_signal |-> !o_dac_valid && !$past(o_stop_signal));

endmodule

// File: rtl/audio_recorder_top.sv
`timescale 1ns/1ps

module audio_recorder_top (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  rec_pkg::rec_event_t          i_event,
    input  logic [rec_pkg::SAMPLE_W-1:0] i_adc_data,
    input  logic                         i_adc_valid,
    output logic                         o_adc_ready,
    output rec_pkg::mem_req_t            o_mem,
    input  logic [rec_pkg::SAMPLE_W-1:0] i_mem_rdata,
    output logic [rec_pkg::SAMPLE_W-1:0] o_dac_data,
    output logic                         o_dac_valid,
    input  logic                         i_dac_ready,
    output logic                         o_stop_signal
);
    import rec_pkg::*;

    logic              play_start;
    logic              play_accept;  // DAC handshake
    logic [ADDR_W-1:0] play_addr;
    logic [ADDR_W-1:0] next_addr;
    logic              at_boundary;

    rec_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_event       (i_event),
        .i_adc_data    (i_adc_data),
        .i_adc_valid   (i_adc_valid),
        .o_adc_ready   (o_adc_ready),
        .o_mem         (o_mem),
        .i_mem_rdata   (i_mem_rdata),
        .i_dac_ready   (i_dac_ready),
        .o_dac_valid   (o_dac_valid),
        .o_stop_signal (o_stop_signal),
        .o_play_start  (play_start),
        .o_play_accept (play_accept),
        .o_play_addr   (play_addr),
        .i_next_addr   (next_addr),
        .i_at_boundary (at_boundary)
    );

    play_stepper u_step (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (play_start),
        .i_accept      (play_accept),
        .i_mode        (i_event.mode),
        .i_speed       (i_event.speed),
        .i_interp      (i_event.interp),
        .i_addr        (play_addr),
        .i_word        (i_mem_rdata),
        .o_next_addr   (next_addr),
        .o_at_boundary (at_boundary),
        .o_sample      (o_dac_data)
    );

endmodule

// File: verif/tb_ref_model.svh
// per-step ramp of slow playback from the shift table
function automatic logic [SAMPLE_W-1:0] slope_model(input logic [SAMPLE_W-1:0] diff,
                                                    input int speed);
    int d;
    int r;
    d = int'($signed(diff));  // sign extended to 32 bits
    case (speed)
        2:       r = d >>> 1;
        3:       r = (d >>> 2) + (d >>> 4) + (d >>> 6);
        4:       r = d >>> 2;
        5:       r = (d >>> 3) + (d >>> 4) + (d >>> 6);
        6:       r = (d >>> 3) + (d >>> 5) + (d >>> 7);
        7:       r = (d >>> 3) + (d >>> 6) + (d >>> 9);
        8:       r = d >>> 3;
        default: r = 0;
    endcase
    return SAMPLE_W'(r);
endfunction

// header word 0 carries the high half
function automatic logic [SAMPLE_W-1:0] header_half(input logic [LEN_W-1:0] len, input int idx);
    return (idx == 0) ? len[LEN_W-1:SAMPLE_W] : len[SAMPLE_W-1:0];
endfunction

// fills exp_q with the DAC sequence for one full playback of rec_words
function automatic void predict_playback(input play_mode_e mode, input int speed,
                                         input bit interp);
    int                  len;
    int                  s;
    int                  a;
    logic [SAMPLE_W-1:0] p;
    logic [SAMPLE_W-1:0] w;
    logic [SAMPLE_W-1:0] step;
    exp_q.delete();
    s   = (speed == 0) ? 1 : speed;
    len = HDR_WORDS + rec_words.size();
    p   = '0;
    a   = HDR_WORDS;
    while (a < len) begin
        w = rec_words[a - HDR_WORDS];
        if (mode == MODE_SLOW) begin
            step = slope_model(w - p, s);
            for (int k = 0; k < s; k++)
                exp_q.push_back(interp ? p + SAMPLE_W'(k) * step : p);
            p = w;  // word passed after its last repeat
            a = a + 1;
        end else begin
            exp_q.push_back(w);
            a = a + ((mode == MODE_FAST) ? s : 1);
        end
    end
endfunction

// File: verif/tb_audio_recorder.sv
`timescale 1ns/1ps

module tb_audio_recorder;
    import rec_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_REC      = 30;
    localparam int N_PART     = 12;
    localparam int PAUSE_AT   = 7;      // outputs before the playback pause
    localparam int WAIT_LIMIT = 10000;  // cycles per wait loop
    localparam int NO_LIMIT   = 1 << 30;

    logic                i_clk;
    logic                i_rst;
    rec_event_t          i_event;
    logic [SAMPLE_W-1:0] i_adc_data;
    logic                i_adc_valid;
    logic                o_adc_ready;
    mem_req_t            o_mem;
    logic [SAMPLE_W-1:0] i_mem_rdata;
    logic [SAMPLE_W-1:0] o_dac_data;
    logic                o_dac_valid;
    logic                i_dac_ready;
    logic                o_stop_signal;

    logic [SAMPLE_W-1:0] mem [0:(1 << ADDR_W)-1];
    logic [SAMPLE_W-1:0] rec_words[$];  // samples as accepted by the ADC side
    logic [SAMPLE_W-1:0] exp_q[$];
    logic [SAMPLE_W-1:0] got_q[$];
    logic                stop_seen;
    int                  seed = 40667;

    `include "tb_ref_model.svh"

    audio_recorder_top dut0 (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_event       (i_event),
        .i_adc_data    (i_adc_data),
        .i_adc_valid   (i_adc_valid),
        .o_adc_ready   (o_adc_ready),
        .o_mem         (o_mem),
        .i_mem_rdata   (i_mem_rdata),
        .o_dac_data    (o_dac_data),
        .o_dac_valid   (o_dac_valid),
        .i_dac_ready   (i_dac_ready),
        .o_stop_signal (o_stop_signal)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // word memory with synchronous write and combinational read
    always @(posedge i_clk) begin
        if (o_mem.we) mem[o_mem.addr] <= o_mem.wdata;
    end
    assign i_mem_rdata = o_mem.re ? mem[o_mem.addr] : '0;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
            stop_on_error($sformatf("CHECK FAILED %s actual 0x%0h expected 0x%0h",
                                    name, actual, expected));
    endtask

    // one-cycle command pulse
    task automatic send_cmd(input rec_code_e code);
        @(posedge i_clk);
        i_event.code <= code;
        @(posedge i_clk);
        i_event.code <= REC_NONE;
    endtask

    task automatic set_mode(input play_mode_e mode, input int speed, input bit interp);
        @(posedge i_clk);
        i_event.mode   <= mode;
        i_event.speed  <= 4'(speed);
        i_event.interp <= interp;
        predict_playback(mode, speed, interp);
    endtask

    task automatic record_samples(input int n);
        int cnt;
        int cyc;
        cnt = 0;
        cyc = 0;
        while (cnt < n) begin
            @(posedge i_clk);
            i_adc_valid <= ($random(seed) & 3) != 0;  // gap about one cycle in four
            i_adc_data  <= $random(seed);
            @(negedge i_clk);
            if (o_adc_ready && i_adc_valid) begin
                rec_words.push_back(i_adc_data);
                cnt++;
            end
            cyc++;
            if (cyc > WAIT_LIMIT) stop_on_error("timed out waiting for ADC samples to transfer");
        end
    endtask

    // stop or pause then watch both header writes
    task automatic end_record(input rec_code_e code);
        logic [LEN_W-1:0] len;
        len = LEN_W'(HDR_WORDS + rec_words.size());
        @(posedge i_clk);
        i_adc_valid  <= 1'b0;
        i_event.code <= code;
        @(posedge i_clk);
        i_event.code <= REC_NONE;
        for (int h = 0; h < HDR_WORDS; h++) begin
            @(negedge i_clk);
            check("o_mem.we", o_mem.we, 1);
            check("o_mem.addr", o_mem.addr, h);
            check("o_mem.wdata", o_mem.wdata, header_half(len, h));
        end
        @(negedge i_clk);
    endtask

    task automatic check_memory();
        logic [LEN_W-1:0] len;
        len = LEN_W'(HDR_WORDS + rec_words.size());
        check("mem[0]", mem[0], header_half(len, 0));
        check("mem[1]", mem[1], header_half(len, 1));
        foreach (rec_words[i])
            check($sformatf("mem[%0d]", i + HDR_WORDS), mem[i + HDR_WORDS], rec_words[i]);
    endtask

    task automatic consume(input int limit);
        int cyc;
        cyc = 0;
        while (!stop_seen && got_q.size() < limit) begin
            @(posedge i_clk);
            i_dac_ready <= ($random(seed) & 3) != 0;
            @(negedge i_clk);
            if (o_dac_valid && i_dac_ready) got_q.push_back(o_dac_data);
            if (o_stop_signal) begin
                check("o_dac_valid", o_dac_valid, 0);  // stream closed with the pulse
                stop_seen = 1'b1;
            end
            cyc++;
            if (cyc > WAIT_LIMIT) stop_on_error("timed out waiting for the end of playback");
        end
    endtask

    task automatic pause_play();
        @(posedge i_clk);
        i_event.code <= REC_PAUSE;
        i_dac_ready  <= 1'b0;
        @(posedge i_clk);
        i_event.code <= REC_NONE;
        @(negedge i_clk);
        check("o_dac_valid", o_dac_valid, 0);
        repeat (4) @(posedge i_clk);
    endtask

    // full playback optionally paused after pause_at outputs
    task automatic play_and_compare(input int pause_at);
        got_q.delete();
        stop_seen = 1'b0;
        send_cmd(REC_PLAY);
        if (pause_at >= 0) begin
            consume(pause_at);
            pause_play();
            send_cmd(REC_PLAY);  // resumes without a header read
        end
        consume(NO_LIMIT);
        @(negedge i_clk);
        check("o_stop_signal", o_stop_signal, 0);
        check("dac sample count", got_q.size(), exp_q.size());
        foreach (exp_q[i])
            check($sformatf("o_dac_data[%0d]", i), got_q[i], exp_q[i]);
    endtask

    initial begin
        int spd;
        i_rst       = 1'b1;
        i_event     = '0;
        i_adc_data  = '0;
        i_adc_valid = 1'b0;
        i_dac_ready = 1'b0;
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check("o_adc_ready", o_adc_ready, 0);
        check("o_dac_valid", o_dac_valid, 0);
        check("o_stop_signal", o_stop_signal, 0);
        check("o_mem.we", o_mem.we, 0);
        check("o_mem.re", o_mem.re, 0);

        // one recording played in every mode
        send_cmd(REC_RECORD);
        rec_words.delete();
        record_samples(N_REC);
        end_record(REC_STOP);
        check_memory();
        set_mode(MODE_NORMAL, 1, 1'b0);
        play_and_compare(-1);
        spd = ($random(seed) & 7) + 1;
        set_mode(MODE_FAST, spd, 1'b0);
        play_and_compare(-1);
        spd = ($random(seed) & 7) + 1;
        set_mode(MODE_SLOW, spd, 1'b0);
        play_and_compare(-1);
        spd = ($random(seed) & 7) + 1;
        set_mode(MODE_SLOW, spd, 1'b1);
        play_and_compare(-1);

        // record in two parts then play with and without a pause
        send_cmd(REC_RECORD);
        rec_words.delete();
        record_samples(N_PART);
        end_record(REC_PAUSE);
        send_cmd(REC_RECORD);
        record_samples(N_PART - 2);
        end_record(REC_STOP);
        check_memory();
        spd = ($random(seed) & 7) + 1;
        set_mode(MODE_SLOW, spd, 1'b1);
        play_and_compare(-1);
        play_and_compare(PAUSE_AT);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+verif
rtl/rec_pkg.sv
rtl/interp_slope.sv
rtl/play_stepper.sv
rtl/rec_ctrl.sv
rtl/audio_recorder_top.sv
verif/tb_audio_recorder.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the audio recorder testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_audio_recorder \
    -f flist.f --Mdir obj_dir -o tb_audio_recorder
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_audio_recorder > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
